//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] lfsr = 32'he6d0_4a70;
logic [31:0] mReg [0:15];     // Model registers, 0 and 15 unused
logic [31:0] mPc;
logic [31:0] mMem [0:255];    // Model of the data range

// Fibonacci taps 32, 22, 2, 1
function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = 32'd0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        val  = {val[30:0], fb};
    end
    return val;
endfunction

function automatic logic [3:0] randReg();
    logic [3:0] r;
    r = 4'(randBits(4));
    while (r == 4'd0 || r == 4'd15)
        r = 4'(randBits(4));
    return r;
endfunction

function automatic cpuPkg::aluOp randOp();
    logic [3:0] o;
    o = 4'(randBits(4));
    while (o == 4'd4 || o == 4'd15)   // Skip reserved codes
        o = 4'(randBits(4));
    return cpuPkg::aluOp'(o);
endfunction

function automatic logic [31:0] genAlu(input logic [3:0] z, input logic st);
    cpuPkg::insnFields f;
    f.kind  = 1'(randBits(1));
    f.store = st;
    f.deref = 1'b0;
    f.z     = z;
    f.x     = 4'(randBits(4));
    f.y     = 4'(randBits(4));
    f.op    = randOp();
    f.imm   = 12'(randBits(12));
    if (f.op == cpuPkg::opShl || f.op == cpuPkg::opShr) begin
        f.kind = 1'b1;                   // Shift amount from the immediate
        f.imm  = 12'(randBits(5));
    end
    return f;
endfunction

// Result is the immediate itself, used for addresses
function automatic logic [31:0] genImm(input logic [3:0] z, input logic [7:0] a,
                                       input logic st, input logic dr);
    cpuPkg::insnFields f;
    f = '0;
    f.store = st;
    f.deref = dr;
    f.z     = z;
    f.op    = cpuPkg::opOr;
    f.imm   = {4'd0, a};
    return f;
endfunction

function automatic logic [31:0] rdReg(input logic [3:0] i);
    if (i == 4'd0)
        return 32'd0;
    if (i == 4'd15)
        return mPc + 32'd1;
    return mReg[i];
endfunction

function automatic logic [31:0] aluRef(input cpuPkg::aluOp op, input logic [31:0] a,
                                       input logic [31:0] b);
    case (op)
        cpuPkg::opOr:   return a | b;
        cpuPkg::opAnd:  return a & b;
        cpuPkg::opAdd:  return a + b;
        cpuPkg::opMul:  return a * b;
        cpuPkg::opShl:  return a << b[4:0];
        cpuPkg::opLt:   return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
        cpuPkg::opEq:   return (a == b) ? 32'hFFFF_FFFF : 32'd0;
        cpuPkg::opGt:   return ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
        cpuPkg::opAndn: return a & ~b;
        cpuPkg::opXor:  return a ^ b;
        cpuPkg::opXnor: return ~(a ^ b);
        cpuPkg::opSub:  return a - b;
        cpuPkg::opShr:  return a >> b[4:0];
        cpuPkg::opNe:   return (a != b) ? 32'hFFFF_FFFF : 32'd0;
        default:        return 32'd0;
    endcase
endfunction

// Runs one instruction on the model, returns the bus request it makes
function automatic cpuPkg::dataReq execModel(input logic [31:0] insn);
    cpuPkg::insnFields f;
    cpuPkg::dataReq    req;
    logic [31:0]       immv;
    logic [31:0]       res;
    logic [31:0]       nxt;
    f    = cpuPkg::insnFields'(insn);
    immv = {{20{f.imm[11]}}, f.imm};
    res  = aluRef(f.op, rdReg(f.x), f.kind ? immv : rdReg(f.y)) + (f.kind ? rdReg(f.y) : immv);
    req  = '0;
    nxt  = mPc + 32'd1;
    if (f.store) begin
        req.strobe = 1'b1;
        req.write  = 1'b1;
        req.addr   = f.deref ? res : rdReg(f.z);
        req.wrData = f.deref ? rdReg(f.z) : res;
        mMem[req.addr[7:0]] = req.wrData;
    end else begin
        if (f.deref) begin
            req.strobe = 1'b1;
            req.addr   = res;
            res        = mMem[res[7:0]];
        end
        if (f.z == 4'd15)
            nxt = res;                   // Jump
        else if (f.z != 4'd0)
            mReg[f.z] = res;
    end
    mPc = nxt;
    return req;
endfunction

`endif

//--- bench/cpuCoreTb.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module cpuCoreTb;

    localparam int aluCount    = 40;
    localparam int loadCount   = 8;
    localparam int branchCount = 6;
    localparam int totalInsns  = 14 + aluCount * 3 + loadCount * 2 + branchCount * 2 + 20;
    localparam int insnCycles  = 8 + `EXEC_WAIT;

    logic           clk = 1'b0;
    logic           reset_n;
    logic           trap;
    logic           haltReq;
    logic [31:0]    iData;
    logic [31:0]    dRdData;
    logic [31:0]    iAddr;
    cpuPkg::dataReq dReq;
    logic           halted;

    logic [31:0]    imem [0:4095];       // Indexed by the low fetch address bits
    logic [31:0]    dmem [0:255];
    cpuPkg::dataReq expReqQ [$];
    logic [31:0]    expAddrQ [$];
    logic [31:0]    lastAddr;
    logic [31:0]    trapPc;
    logic           trapArmed = 1'b0;
    logic           checking = 1'b0;
    int             errorCount = 0;
    int             progLen;

    `include "isaModel.svh"

    cpuCore dut (
        .clk     (clk),
        .reset_n (reset_n),
        .iData   (iData),
        .dRdData (dRdData),
        .trap    (trap),
        .haltReq (haltReq),
        .iAddr   (iAddr),
        .dReq    (dReq),
        .halted  (halted)
    );

    always #10 clk = ~clk;

    assign iData   = imem[iAddr[11:0]];
    assign dRdData = dmem[dReq.addr[7:0]];

    always @(posedge clk) begin
        if (dReq.strobe && dReq.write)
            dmem[dReq.addr[7:0]] <= dReq.wrData;
        trap <= trapArmed && (iAddr == trapPc);   // High through the exec step of trapPc
    end

    task automatic checkReq(input cpuPkg::dataReq got, input cpuPkg::dataReq exp);
        if (got.strobe !== exp.strobe) begin
            $display("Error: dReq.strobe got %h expected %h", got.strobe, exp.strobe);
            errorCount++;
        end else if (exp.strobe) begin
            if (got.write !== exp.write) begin
                $display("Error: dReq.write got %h expected %h", got.write, exp.write);
                errorCount++;
            end
            if (got.addr !== exp.addr) begin
                $display("Error: dReq.addr got %h expected %h", got.addr, exp.addr);
                errorCount++;
            end
            if (exp.write && got.wrData !== exp.wrData) begin
                $display("Error: dReq.wrData got %h expected %h", got.wrData, exp.wrData);
                errorCount++;
            end
        end
    endtask

    task automatic checkAddr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: iAddr got %h expected %h", got, exp);
            errorCount++;
        end
    endtask

    task automatic checkHalt(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: halted got %h expected %h", got, exp);
            errorCount++;
        end
    endtask

    // Compare process
    always @(negedge clk) begin
        if (checking) begin
            if (dReq.strobe) begin
                if (expReqQ.size() == 0) begin
                    $display("Unexpected data bus strobe at address %h", dReq.addr);
                    errorCount++;
                end else begin
                    checkReq(dReq, expReqQ.pop_front());
                end
            end
            if (iAddr !== lastAddr) begin
                if (expAddrQ.size() == 0) begin
                    $display("Unexpected fetch address change to %h", iAddr);
                    errorCount++;
                end else begin
                    checkAddr(iAddr, expAddrQ.pop_front());
                end
            end
        end
        lastAddr = iAddr;
    end

    task automatic emit(input logic [31:0] insn);
        cpuPkg::dataReq req;
        imem[mPc[11:0]] = insn;
        req = execModel(insn);
        if (req.strobe)
            expReqQ.push_back(req);
        expAddrQ.push_back(mPc);
        progLen++;
    endtask

    // Trapped instruction is skipped and only its return address is stored
    task automatic emitTrap(input logic [31:0] insn);
        cpuPkg::dataReq req;
        imem[mPc[11:0]] = insn;
        trapPc = mPc;
        req = {1'b1, 1'b1, `TRAP_ADDR, mPc};
        expReqQ.push_back(req);
        mMem[req.addr[7:0]] = mPc;
        mPc = `TRAP_VECTOR;
        expAddrQ.push_back(mPc);
        progLen++;
    endtask

    task automatic plainStore();
        logic [3:0] s;
        s = randReg();
        emit(genImm(s, 8'(randBits(8)), 1'b0, 1'b0));   // Address into s
        emit(genAlu(s, 1'b1));
    endtask

    task automatic resetCore();
        @(posedge clk);
        checking = 1'b0;
        reset_n <= 1'b0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        checking = 1'b1;
        @(negedge clk);
        checkHalt(halted, 1'b0);
        checkAddr(iAddr, `RESET_VECTOR);
        checkReq(dReq, '0);
    endtask

    task automatic runProgram();
        int n;
        imem[mPc[11:0]] = 32'hFFFF_FFFF;    // Illegal word never commits
        progLen++;
        resetCore();
        n = 0;
        while (!halted && n < progLen * insnCycles + 20) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            $display("Core did not halt within %0d cycles", n);
            errorCount++;
        end
        checkHalt(halted, 1'b1);
        repeat (5) @(negedge clk);       // No strobes after the halt
        if (expReqQ.size() != 0 || expAddrQ.size() != 0) begin
            $display("Expected bus requests or fetches were never seen");
            errorCount++;
        end
        expReqQ.delete();
        expAddrQ.delete();
    endtask

    task automatic startProgram();
        mPc = `RESET_VECTOR;
        progLen = 0;
    endtask

    initial begin
        logic [3:0] r;
        reset_n = 1'b0;
        trap    = 1'b0;
        haltReq = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hC3A5_0000 ^ (i * 32'h0101_0307);
            mMem[i] = dmem[i];
        end
        for (int i = 0; i < 16; i++)
            mReg[i] = 32'd0;

        startProgram();
        for (int i = 1; i < 15; i++)
            emit(genImm(4'(i), 8'(randBits(8)), 1'b0, 1'b0));
        for (int i = 0; i < aluCount; i++) begin
            emit(genAlu(randReg(), 1'b0));
            plainStore();
        end
        runProgram();

        startProgram();
        for (int i = 0; i < loadCount; i++) begin
            r = randReg();
            emit(genImm(r, 8'(randBits(8)), 1'b0, 1'b1));   // Load into r
            emit(genImm(r, 8'(randBits(8)), 1'b1, 1'b1));   // Store r back
        end
        runProgram();

        startProgram();
        for (int i = 0; i < branchCount; i++) begin
            emit(genAlu(randReg(), 1'b0));
            emit({1'b0, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, cpuPkg::opAdd,
                  12'(randBits(2) + 1)});                   // Jump ahead of pc + 1
        end
        emit(genAlu(4'd0, 1'b0));
        emit(genImm(4'd0, 8'(randBits(8)), 1'b1, 1'b1));    // Register 0 still zero
        plainStore();
        runProgram();

        startProgram();
        for (int i = 0; i < 3; i++)
            emit(genAlu(randReg(), 1'b0));
        emitTrap(genAlu(randReg(), 1'b0));
        plainStore();
        trapArmed = 1'b1;
        runProgram();
        trapArmed = 1'b0;

        @(posedge clk);
        haltReq <= 1'b1;
        resetCore();
        repeat (10) begin
            @(negedge clk);
            checkAddr(iAddr, `RESET_VECTOR);
            checkReq(dReq, '0);
        end

        $display("Finished with %0d errors", errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // Watchdog
    initial begin
        #(totalInsns * insnCycles * 20 + 5000);
        $display("Simulation timed out before all tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

//--- cpuCore.f
+incdir+src
+incdir+bench
src/cpuPkg.sv
src/regFile.sv
src/insnDecoder.sv
src/aluExec.sv
src/stepTimer.sv
src/coreControl.sv
src/memAccess.sv
src/cpuCore.sv
bench/cpuCoreTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module cpuCoreTb -f cpuCore.f -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    && grep -q "^No errors$" sim.log \
    && echo "PASS" \
    || (echo "FAIL, see build.log and sim.log"; exit 1)

//--- src/aluExec.sv
`timescale 1ns/1ps

module aluExec (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               en,
    input  cpuPkg::aluOp       op,
    input  logic               swap,
    input  logic [31:0]        x,
    input  logic [31:0]        y,
    input  logic [31:0]        imm,
    output logic [31:0]        result
);

    logic [31:0] operand;
    logic [31:0] addend;
    logic [31:0] opResult;

    assign operand = swap ? imm : y;   // Kind bit trades the two roles
    assign addend  = swap ? y : imm;

    always_comb begin
        case (op)
            cpuPkg::opOr:   opResult = x | operand;
            cpuPkg::opAnd:  opResult = x & operand;
            cpuPkg::opAdd:  opResult = x + operand;
            cpuPkg::opMul:  opResult = x * operand;   // Slow path, covered by wait step
            cpuPkg::opShl:  opResult = x << operand;
            cpuPkg::opLt:   opResult = {32{$signed(x) < $signed(operand)}};
            cpuPkg::opEq:   opResult = {32{x == operand}};
            cpuPkg::opGt:   opResult = {32{$signed(x) > $signed(operand)}};
            cpuPkg::opAndn: opResult = x & ~operand;
            cpuPkg::opXor:  opResult = x ^ operand;
            cpuPkg::opXnor: opResult = x ^~ operand;
            cpuPkg::opSub:  opResult = x - operand;
            cpuPkg::opShr:  opResult = x >> operand;  // Logical
            cpuPkg::opNe:   opResult = {32{x != operand}};
            default:        opResult = 32'd0;         // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            result <= 32'd0;
        end else if (en) begin
            result <= opResult + addend;
        end
    end

endmodule

//--- src/coreControl.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module coreControl (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             illegal,
    input  logic             branch,
    input  logic             store,
    input  logic             trap,
    input  logic             haltReq,
    input  logic             timerDone,
    input  logic [31:0]      result,
    output cpuPkg::coreStep  step,
    output logic [31:0]      iAddr,
    output logic [31:0]      nextPc,
    output logic             execEn,
    output logic             timerStart,
    output logic             regWrite,
    output logic             halted
);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            step       <= cpuPkg::stIdle;
            iAddr      <= `RESET_VECTOR;
            nextPc     <= 32'd0;
            timerStart <= 1'b0;
        end else begin
            timerStart <= 1'b0;                           // Single-cycle pulse
            case (step)
                cpuPkg::stIdle: begin
                    iAddr <= `RESET_VECTOR;
                    step  <= haltReq ? cpuPkg::stIdle : cpuPkg::stNextPc;
                end
                cpuPkg::stNextPc: begin
                    nextPc <= iAddr + 32'd1;              // Word addressed fetch
                    step   <= cpuPkg::stExec;
                end
                cpuPkg::stExec: begin
                    if (haltReq)
                        step <= cpuPkg::stIdle;
                    else if (illegal)
                        step <= cpuPkg::stHalt;
                    else if (trap)
                        step <= cpuPkg::stTrap;
                    else
                        step <= cpuPkg::stLatch;
                end
                cpuPkg::stLatch: begin
                    timerStart <= 1'b1;                   // High in first wait cycle
                    step       <= cpuPkg::stWait;
                end
                cpuPkg::stWait: begin
                    if (timerDone)
                        step <= cpuPkg::stMem;
                end
                cpuPkg::stMem: begin
                    step <= cpuPkg::stCommit;
                end
                cpuPkg::stCommit: begin
                    iAddr <= branch ? result : nextPc;    // Jump through Z = 15
                    step  <= cpuPkg::stNextPc;
                end
                cpuPkg::stTrap: begin
                    step <= cpuPkg::stTrapStore;          // Return address latched now
                end
                cpuPkg::stTrapStore: begin
                    iAddr <= `TRAP_VECTOR;
                    step  <= cpuPkg::stNextPc;
                end
                cpuPkg::stHalt: begin
                    step <= cpuPkg::stHalt;               // Only reset leaves
                end
                default: begin
                    step <= cpuPkg::stHalt;
                end
            endcase
        end
    end

    assign execEn   = step == cpuPkg::stExec;
    assign regWrite = (step == cpuPkg::stCommit) && !store;
    assign halted   = step == cpuPkg::stHalt;

endmodule

//--- src/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic            clk,
    input  logic            reset_n,
    input  logic [31:0]     iData,
    input  logic [31:0]     dRdData,
    input  logic            trap,
    input  logic            haltReq,
    output logic [31:0]     iAddr,
    output cpuPkg::dataReq  dReq,
    output logic            halted
);

    cpuPkg::coreStep    step;
    cpuPkg::insnFields  fields;
    logic [31:0]        nextPc;
    logic [31:0]        immExt;
    logic [31:0]        xVal;
    logic [31:0]        yVal;
    logic [31:0]        zVal;
    logic [31:0]        aluResult;
    logic [31:0]        commitVal;
    logic               illegal;
    logic               branch;
    logic               loading;
    logic               execEn;
    logic               timerStart;
    logic               timerDone;
    logic               regWrite;

    coreControl control (
        .clk        (clk),
        .reset_n    (reset_n),
        .illegal    (illegal),
        .branch     (branch),
        .store      (fields.store),
        .trap       (trap),
        .haltReq    (haltReq),
        .timerDone  (timerDone),
        .result     (commitVal),
        .step       (step),
        .iAddr      (iAddr),
        .nextPc     (nextPc),
        .execEn     (execEn),
        .timerStart (timerStart),
        .regWrite   (regWrite),
        .halted     (halted)
    );

    stepTimer timer (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (timerStart),
        .done    (timerDone)
    );

    insnDecoder decoder (
        .insn    (iData),            // Held stable until the end of commit
        .fields  (fields),
        .immExt  (immExt),
        .illegal (illegal),
        .branch  (branch),
        .loading (loading)
    );

    regFile regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .xIdx      (fields.x),
        .yIdx      (fields.y),
        .zIdx      (fields.z),
        .nextPc    (nextPc),
        .writeEn   (regWrite),
        .writeData (commitVal),
        .xVal      (xVal),
        .yVal      (yVal),
        .zVal      (zVal)
    );

    aluExec alu (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (execEn),
        .op      (fields.op),
        .swap    (fields.kind),
        .x       (xVal),
        .y       (yVal),
        .imm     (immExt),
        .result  (aluResult)
    );

    memAccess mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .step      (step),
        .fields    (fields),
        .loading   (loading),
        .aluResult (aluResult),
        .zVal      (zVal),
        .iAddr     (iAddr),
        .dRdData   (dRdData),
        .commitVal (commitVal),
        .dReq      (dReq)
    );

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    // Operation codes in the low nibble above the immediate
    typedef enum logic [3:0] {
        opOr    = 4'd0,
        opAnd   = 4'd1,
        opAdd   = 4'd2,
        opMul   = 4'd3,
        opRes4  = 4'd4,   // Reserved, yields zero
        opShl   = 4'd5,
        opLt    = 4'd6,
        opEq    = 4'd7,
        opGt    = 4'd8,
        opAndn  = 4'd9,
        opXor   = 4'd10,
        opXnor  = 4'd11,
        opSub   = 4'd12,
        opShr   = 4'd13,
        opNe    = 4'd14,
        opRes15 = 4'd15   // Reserved, yields zero
    } aluOp;

    // Overlay of one instruction word, MSB first
    typedef struct packed {
        logic       kind;     // Swaps Y and immediate roles
        logic       store;
        logic       deref;
        logic [3:0] z;
        logic [3:0] x;
        logic [3:0] y;
        aluOp       op;
        logic [11:0] imm;
    } insnFields;

    typedef enum logic [3:0] {
        stIdle,
        stExec,
        stLatch,
        stWait,
        stMem,
        stCommit,
        stNextPc,
        stHalt,
        stTrap,
        stTrapStore
    } coreStep;

    // One data bus request, valid while strobe is high
    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wrData;
    } dataReq;

endpackage

//--- src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// First fetch address after reset or a halt request
`define RESET_VECTOR 32'h0000_1000

// Fetch address taken after a trap
`define TRAP_VECTOR 32'h0000_0800

// Data word that receives the return address on a trap
`define TRAP_ADDR 32'h0000_0040

// Extra cycles spent in the wait step for the multiplier
`define EXEC_WAIT 1

`endif

//--- src/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  logic [31:0]        insn,
    output cpuPkg::insnFields  fields,
    output logic [31:0]        immExt,
    output logic               illegal,
    output logic               branch,
    output logic               loading
);

    assign fields = cpuPkg::insnFields'(insn);

    // Immediate is signed, 12 bits
    assign immExt = {{20{fields.imm[11]}}, fields.imm};

    assign illegal = &insn;                                   // All ones stops the core

    // Writing the PC view is a jump
    assign branch = (fields.z == 4'd15) && !fields.store;

    assign loading = fields.deref && !fields.store;           // Result comes from memory

endmodule

//--- src/memAccess.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module memAccess (
    input  logic               clk,
    input  logic               reset_n,
    input  cpuPkg::coreStep    step,
    input  cpuPkg::insnFields  fields,
    input  logic               loading,
    input  logic [31:0]        aluResult,
    input  logic [31:0]        zVal,
    input  logic [31:0]        iAddr,
    input  logic [31:0]        dRdData,
    output logic [31:0]        commitVal,
    output cpuPkg::dataReq     dReq
);

    logic [31:0] resultQ;   // ALU result, or return address on a trap
    logic [31:0] loadQ;
    logic        memStep;
    logic        trapStep;

    assign memStep  = step == cpuPkg::stMem;
    assign trapStep = step == cpuPkg::stTrapStore;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            resultQ <= 32'd0;
            loadQ   <= 32'd0;
        end else begin
            if (step == cpuPkg::stLatch)
                resultQ <= aluResult;
            else if (step == cpuPkg::stTrap)
                resultQ <= iAddr;            // Address of the trapped instruction
            if (memStep)
                loadQ <= dRdData;
        end
    end

    assign commitVal = loading ? loadQ : resultQ;

    assign dReq.strobe = (memStep && (fields.store || loading)) || trapStep;
    assign dReq.write  = (memStep && fields.store) || trapStep;

    // Deref puts the result on the address, otherwise Z is the address
    assign dReq.addr = trapStep     ? `TRAP_ADDR :
                       fields.deref ? resultQ : zVal;

    assign dReq.wrData = trapStep     ? resultQ :
                         fields.deref ? zVal : resultQ;

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [3:0]  xIdx,
    input  logic [3:0]  yIdx,
    input  logic [3:0]  zIdx,
    input  logic [31:0] nextPc,
    input  logic        writeEn,
    input  logic [31:0] writeData,
    output logic [31:0] xVal,
    output logic [31:0] yVal,
    output logic [31:0] zVal
);

    logic [31:0] regs [1:14];   // Entries 0 and 15 are not stored

    function automatic logic [31:0] readPort(input logic [3:0] idx, input logic [31:0] pc);
        logic [31:0] val;
        if (idx == 4'd0)
            val = 32'd0;
        else if (idx == 4'd15)
            val = pc;                // PC view
        else
            val = regs[idx];
        return val;
    endfunction

    assign xVal = readPort(xIdx, nextPc);
    assign yVal = readPort(yIdx, nextPc);
    assign zVal = readPort(zIdx, nextPc);

    // Writes to 0 and 15 fall away, nothing lands while in reset
    always_ff @(posedge clk) begin
        if (reset_n && writeEn && zIdx != 4'd0 && zIdx != 4'd15) begin
            regs[zIdx] <= writeData;
        end
    end

endmodule

//--- src/stepTimer.sv
`include "cpu_defines.svh"
`timescale 1ns/1ps

module stepTimer (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    output logic done
);

    localparam logic [7:0] waitLen = 8'(`EXEC_WAIT);

    logic [7:0] count;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= 8'd0;
        end else if (start) begin
            count <= waitLen;             // Reload on each wait step
        end else if (count != 8'd0) begin
            count <= count - 8'd1;
        end
    end

    // Last cycle of the count
    assign done = count == 8'd1;

endmodule
